// ==== hw/msi_params.svh ====
/*
 * Width and size constants for the interrupt-to-MSI bridge.
 * Include in any RTL or testbench file that sizes a port or a field.
 */
`ifndef MSI_PARAMS_SVH
`define MSI_PARAMS_SVH

// AXI4-Lite write channel widths
`define MSI_ADDR_W 32
`define MSI_DATA_W 64
`define MSI_STRB_W (`MSI_DATA_W / 8)

// Interrupt lines and the index that selects one of them
`define MSI_NUM_IRQ 4
`define MSI_IRQ_IDX_W 2

// Destination base addresses and the index that selects one
`define MSI_NUM_DEST 2
`define MSI_DEST_W 1

// Message ids carried per line
`define MSI_DEV_ID_W 16
`define MSI_EVT_ID_W 16

// Throttle gap counter
`define MSI_THR_W 8

`endif

// ==== hw/msi_pkg.sv ====
/*
 * Types shared by the MSI bridge RTL and its testbench.
 * Refer to items by scoped name, e.g. msi_pkg::msi_req_t.
 */
`include "msi_params.svh"

package msi_pkg;

  // Static configuration of one interrupt line
  typedef struct packed {
    logic                     enable;
    logic [`MSI_DEST_W-1:0]   dest_idx;
    logic [`MSI_DEV_ID_W-1:0] device_id;
    logic [`MSI_EVT_ID_W-1:0] event_id;
  } irq_cfg_t;

  // One message handed from the arbiter to the write issuer
  typedef struct packed {
    logic [`MSI_DEST_W-1:0]   dest_idx;
    logic [`MSI_DEV_ID_W-1:0] device_id;
    logic [`MSI_EVT_ID_W-1:0] event_id;
  } msi_req_t;

  // Write issuer FSM
  typedef enum logic [1:0] {
    IDLE,
    SEND,
    RESP,
    GAP
  } issuer_state_e;

  // AXI response codes as carried on bresp
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

endpackage

// ==== hw/msi_irq_arbiter.sv ====
/*
 * Turns enabled interrupt rising edges into pending bits and hands one
 * pending line at a time to the write issuer, round-robin.
 */
`timescale 1ns/1ps
`include "msi_params.svh"

module msi_irq_arbiter (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic              [`MSI_NUM_IRQ-1:0]  irq,
  input  msi_pkg::irq_cfg_t [`MSI_NUM_IRQ-1:0]  irq_cfg,
  output msi_pkg::msi_req_t                     req,
  output logic                                  req_valid,
  input  logic                                  req_ready
);

  logic [`MSI_NUM_IRQ-1:0]   irq_q;
  logic [`MSI_NUM_IRQ-1:0]   irq_en;
  logic [`MSI_NUM_IRQ-1:0]   irq_rise;
  logic [`MSI_NUM_IRQ-1:0]   pending;
  logic [`MSI_NUM_IRQ-1:0]   grant_clr;
  logic [`MSI_IRQ_IDX_W-1:0] rr_ptr;
  logic [`MSI_IRQ_IDX_W-1:0] grant_idx;
  logic [`MSI_IRQ_IDX_W-1:0] pick_idx;
  logic                      pick_found;
  logic                      xfer;

  function automatic logic [`MSI_IRQ_IDX_W-1:0] wrap_idx(input int unsigned pos);
    return `MSI_IRQ_IDX_W'(pos % `MSI_NUM_IRQ);
  endfunction

  always_comb begin
    for (int i = 0; i < `MSI_NUM_IRQ; i++) begin
      irq_en[i] = irq_cfg[i].enable;
    end
  end

  assign irq_rise  = irq & ~irq_q;
  assign xfer      = req_valid & req_ready;
  assign grant_clr = xfer ? (`MSI_NUM_IRQ'(1) << grant_idx) : '0;

  // Repeated edges on a line that is already pending merge into one bit
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      irq_q   <= '0;
      pending <= '0;
    end else begin
      irq_q   <= irq;
      pending <= (pending & ~grant_clr) | (irq_rise & irq_en);
    end
  end

  // First pending line at or after the pointer
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int k = 0; k < `MSI_NUM_IRQ; k++) begin
      if (!pick_found && pending[wrap_idx(rr_ptr + k)]) begin
        pick_found = 1'b1;
        pick_idx   = wrap_idx(rr_ptr + k);
      end
    end
  end

  // A new grant is only taken while none is outstanding
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      req_valid <= 1'b0;
      grant_idx <= '0;
      rr_ptr    <= '0;
    end else if (xfer) begin
      req_valid <= 1'b0;
      rr_ptr    <= wrap_idx(grant_idx + 1);
    end else if (!req_valid && pick_found) begin
      req_valid <= 1'b1;
      grant_idx <= pick_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (!req_valid && pick_found) begin
      req.dest_idx  <= irq_cfg[pick_idx].dest_idx;
      req.device_id <= irq_cfg[pick_idx].device_id;
      req.event_id  <= irq_cfg[pick_idx].event_id;
    end
  end

endmodule

// ==== hw/msi_write_issuer.sv ====
/*
 * Sends each accepted message as one AXI4-Lite write, keeps the optional
 * minimum gap between write starts and pulses error on a bad response.
 */
`timescale 1ns/1ps
`include "msi_params.svh"

module msi_write_issuer (
  input  logic                                       clk,
  input  logic                                       rst,

  // Message from the arbiter
  input  msi_pkg::msi_req_t                          req,
  input  logic                                       req_valid,
  output logic                                       req_ready,

  // Static configuration
  input  logic [`MSI_NUM_DEST-1:0][`MSI_ADDR_W-1:0]  msi_dest_addr,
  input  logic                                       throttle_en,
  input  logic [`MSI_THR_W-1:0]                      throttle_threshold,

  // AXI4-Lite write initiator
  output logic [`MSI_ADDR_W-1:0]                     awaddr,
  output logic                                       awvalid,
  input  logic                                       awready,
  output logic [`MSI_DATA_W-1:0]                     wdata,
  output logic [`MSI_STRB_W-1:0]                     wstrb,
  output logic                                       wvalid,
  input  logic                                       wready,
  input  msi_pkg::axi_resp_e                         bresp,
  input  logic                                       bvalid,
  output logic                                       bready,

  output logic                                       error
);

  msi_pkg::issuer_state_e state;

  logic [`MSI_THR_W-1:0]  thr_cnt;
  logic                   gap_wait;
  logic                   accept;
  logic                   aw_done;
  logic                   w_done;
  logic [`MSI_ADDR_W-1:0] base_addr;
  logic [`MSI_ADDR_W-1:0] dev_offset;
  logic [31:0]            evt_word;
  logic [`MSI_DATA_W-1:0] lane_data;
  logic [`MSI_STRB_W-1:0] lane_strb;

  assign req_ready = (state == msi_pkg::IDLE);
  assign accept    = req_valid & req_ready;
  assign bready    = (state == msi_pkg::RESP);

  // Channel finished once its valid is low or is being taken this cycle
  assign aw_done = !awvalid || awready;
  assign w_done  = !wvalid || wready;

  // thr_cnt holds the threshold in the first awvalid cycle and counts down.
  // Leaving GAP at 2 lets IDLE accept at 1, so the next awvalid rises
  // exactly threshold cycles after the previous one at the earliest.
  assign gap_wait = throttle_en && (thr_cnt > `MSI_THR_W'(2));

  // Address is base plus device id in 32-bit words
  assign base_addr  = msi_dest_addr[req.dest_idx];
  assign dev_offset = `MSI_ADDR_W'({req.device_id, 2'b00});
  assign evt_word   = 32'(req.event_id);

  // Odd device ids use the upper 32-bit lane
  always_comb begin
    if (req.device_id[0]) begin
      lane_data = {evt_word, {(`MSI_DATA_W - 32){1'b0}}};
      lane_strb = {4'hf, {(`MSI_STRB_W - 4){1'b0}}};
    end else begin
      lane_data = {{(`MSI_DATA_W - 32){1'b0}}, evt_word};
      lane_strb = {{(`MSI_STRB_W - 4){1'b0}}, 4'hf};
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= msi_pkg::IDLE;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      error   <= 1'b0;
      thr_cnt <= '0;
    end else begin
      error <= 1'b0;

      if (accept) begin
        thr_cnt <= throttle_threshold;
      end else if (thr_cnt != '0) begin
        thr_cnt <= thr_cnt - 1'b1;
      end

      case (state)
        msi_pkg::IDLE: begin
          if (accept) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            state   <= msi_pkg::SEND;
          end
        end
        msi_pkg::SEND: begin
          // AW and W complete independently
          if (awready) begin
            awvalid <= 1'b0;
          end
          if (wready) begin
            wvalid <= 1'b0;
          end
          if (aw_done && w_done) begin
            state <= msi_pkg::RESP;
          end
        end
        msi_pkg::RESP: begin
          if (bvalid) begin
            error <= (bresp != msi_pkg::OKAY);
            state <= gap_wait ? msi_pkg::GAP : msi_pkg::IDLE;
          end
        end
        msi_pkg::GAP: begin
          if (!gap_wait) begin
            state <= msi_pkg::IDLE;
          end
        end
        default: state <= msi_pkg::IDLE;
      endcase
    end
  end

  // Write payload, captured with the request
  always_ff @(posedge clk) begin
    if (accept) begin
      awaddr <= base_addr + dev_offset;
      wdata  <= lane_data;
      wstrb  <= lane_strb;
    end
  end

endmodule

// ==== hw/axil_msi_gen.sv ====
/*
 * Interrupt-to-MSI bridge top level. Level interrupts in, one AXI4-Lite
 * write per enabled rising edge out. Configuration is held static.
 */
`timescale 1ns/1ps
`include "msi_params.svh"

module axil_msi_gen (
  input  logic                                       clk,
  input  logic                                       rst,

  input  logic              [`MSI_NUM_IRQ-1:0]       irq,
  input  msi_pkg::irq_cfg_t [`MSI_NUM_IRQ-1:0]       irq_cfg,
  input  logic [`MSI_NUM_DEST-1:0][`MSI_ADDR_W-1:0]  msi_dest_addr,
  input  logic                                       throttle_en,
  input  logic [`MSI_THR_W-1:0]                      throttle_threshold,

  // AXI4-Lite write initiator
  output logic [`MSI_ADDR_W-1:0]                     awaddr,
  output logic                                       awvalid,
  input  logic                                       awready,
  output logic [`MSI_DATA_W-1:0]                     wdata,
  output logic [`MSI_STRB_W-1:0]                     wstrb,
  output logic                                       wvalid,
  input  logic                                       wready,
  input  msi_pkg::axi_resp_e                         bresp,
  input  logic                                       bvalid,
  output logic                                       bready,

  output logic                                       error
);

  msi_pkg::msi_req_t req;
  logic              req_valid;
  logic              req_ready;

  msi_irq_arbiter msi_irq_arbiter_i (
    .clk       (clk),
    .rst       (rst),
    .irq       (irq),
    .irq_cfg   (irq_cfg),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready)
  );

  msi_write_issuer msi_write_issuer_i (
    .clk                (clk),
    .rst                (rst),
    .req                (req),
    .req_valid          (req_valid),
    .req_ready          (req_ready),
    .msi_dest_addr      (msi_dest_addr),
    .throttle_en        (throttle_en),
    .throttle_threshold (throttle_threshold),
    .awaddr             (awaddr),
    .awvalid            (awvalid),
    .awready            (awready),
    .wdata              (wdata),
    .wstrb              (wstrb),
    .wvalid             (wvalid),
    .wready             (wready),
    .bresp              (bresp),
    .bvalid             (bvalid),
    .bready             (bready),
    .error              (error)
  );

endmodule

// ==== testbench/axil_msi_checker.sv ====
/*
 * Protocol checks for the MSI bridge, bound to the top level.
 * Covers AXI4-Lite write stability, strobe shape and throttle spacing.
 */
`timescale 1ns/1ps
`include "msi_params.svh"

module axil_msi_checker (
  input logic                   clk,
  input logic                   rst,
  input logic [`MSI_ADDR_W-1:0] awaddr,
  input logic                   awvalid,
  input logic                   awready,
  input logic [`MSI_DATA_W-1:0] wdata,
  input logic [`MSI_STRB_W-1:0] wstrb,
  input logic                   wvalid,
  input logic                   wready,
  input logic                   throttle_en,
  input logic [`MSI_THR_W-1:0]  throttle_threshold
);

  int          fail_count = 0;
  logic        awvalid_q;
  logic        seen_rise;
  logic [15:0] since_rise;
  logic        aw_rise;

  assign aw_rise = awvalid && !awvalid_q;

  // Saturating count of cycles since the last awvalid rise
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      awvalid_q  <= 1'b0;
      seen_rise  <= 1'b0;
      since_rise <= '0;
    end else begin
      awvalid_q <= awvalid;
      if (aw_rise) begin
        seen_rise  <= 1'b1;
        since_rise <= 16'd1;
      end else if (since_rise != 16'hffff) begin
        since_rise <= since_rise + 16'd1;
      end
    end
  end

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
      fail_count++;
      $error("awvalid or awaddr changed before awready");
    end

  w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else begin
      fail_count++;
      $error("wvalid, wdata or wstrb changed before wready");
    end

  // A write start must not land inside the previous gap
  gap_kept: assert property (@(posedge clk) disable iff (rst)
    aw_rise && throttle_en && seen_rise |-> since_rise >= {8'd0, throttle_threshold})
    else begin
      fail_count++;
      $error("awvalid rose %0d cycles after the previous rise", since_rise);
    end

  strb_lane: assert property (@(posedge clk) disable iff (rst)
    wvalid |-> (wstrb == 8'h0f || wstrb == 8'hf0))
    else begin
      fail_count++;
      $error("wstrb %h covers neither a low nor a high lane", wstrb);
    end

endmodule

// ==== testbench/axil_msi_tb.sv ====
/*
 * Directed testbench for the interrupt-to-MSI bridge. Plays the AXI4-Lite
 * write slave, fires interrupt lines and checks every write it takes.
 */
`timescale 1ns/1ps
`include "msi_params.svh"

module axil_msi_tb;

  typedef struct packed {
    logic [`MSI_ADDR_W-1:0] addr;
    logic [`MSI_DATA_W-1:0] data;
    logic [`MSI_STRB_W-1:0] strb;
  } wr_rec_t;

  // Worst case per write is the throttle gap plus stalls on AW, W and B
  localparam int NUM_WRITES  = 13;
  localparam int THR_CYCLES  = 12;
  localparam int MAX_STALL   = 48;
  localparam int CYCLE_LIMIT = NUM_WRITES * (THR_CYCLES + MAX_STALL) + 1000;

  logic                                      clk = 1'b0;
  logic                                      rst;
  logic [`MSI_NUM_IRQ-1:0]                   irq;
  msi_pkg::irq_cfg_t [`MSI_NUM_IRQ-1:0]      irq_cfg;
  logic [`MSI_NUM_DEST-1:0][`MSI_ADDR_W-1:0] msi_dest_addr;
  logic                                      throttle_en;
  logic [`MSI_THR_W-1:0]                     throttle_threshold;
  logic [`MSI_ADDR_W-1:0]                    awaddr;
  logic                                      awvalid;
  logic                                      awready = 1'b0;
  logic [`MSI_DATA_W-1:0]                    wdata;
  logic [`MSI_STRB_W-1:0]                    wstrb;
  logic                                      wvalid;
  logic                                      wready = 1'b0;
  msi_pkg::axi_resp_e                        bresp = msi_pkg::OKAY;
  logic                                      bvalid = 1'b0;
  logic                                      bready;
  logic                                      error;

  // Responder and monitor state
  logic               stall_en = 1'b0;
  msi_pkg::axi_resp_e resp_code = msi_pkg::OKAY;
  logic [31:0]        lfsr_state = 32'h2c02_9fd2;
  logic               aw_seen = 1'b0;
  logic               w_seen = 1'b0;
  logic               b_hs = 1'b0;
  logic               aw_prev = 1'b0;
  logic               exp_error = 1'b0;
  wr_rec_t            cur;
  wr_rec_t            wr_q[$];
  int                 rise_q[$];
  int                 err_pulses = 0;
  int                 ncyc = 0;
  int                 cyc = 0;

  always #10 clk = ~clk;

  axil_msi_gen axil_msi_gen_i (
    .clk                (clk),
    .rst                (rst),
    .irq                (irq),
    .irq_cfg            (irq_cfg),
    .msi_dest_addr      (msi_dest_addr),
    .throttle_en        (throttle_en),
    .throttle_threshold (throttle_threshold),
    .awaddr             (awaddr),
    .awvalid            (awvalid),
    .awready            (awready),
    .wdata              (wdata),
    .wstrb              (wstrb),
    .wvalid             (wvalid),
    .wready             (wready),
    .bresp              (bresp),
    .bvalid             (bvalid),
    .bready             (bready),
    .error              (error)
  );

  bind axil_msi_gen axil_msi_checker axil_msi_checker_i (
    .clk                (clk),
    .rst                (rst),
    .awaddr             (awaddr),
    .awvalid            (awvalid),
    .awready            (awready),
    .wdata              (wdata),
    .wstrb              (wstrb),
    .wvalid             (wvalid),
    .wready             (wready),
    .throttle_en        (throttle_en),
    .throttle_threshold (throttle_threshold)
  );

  // Right-shifting Galois LFSR
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'hd000_0001 : 32'h0000_0000);
  endfunction

  function automatic logic draw_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
    return b;
  endfunction

  function automatic msi_pkg::irq_cfg_t make_cfg(input logic en, input logic dest,
                                                 input logic [15:0] dev,
                                                 input logic [15:0] evt);
    msi_pkg::irq_cfg_t c;
    c.enable    = en;
    c.dest_idx  = dest;
    c.device_id = dev;
    c.event_id  = evt;
    return c;
  endfunction

  // Expected write is base + 4 * device id with the event id in the lane picked by id bit 0
  function automatic wr_rec_t expect_write(input msi_pkg::irq_cfg_t c);
    wr_rec_t r;
    r.addr = msi_dest_addr[c.dest_idx] + {14'd0, c.device_id, 2'b00};
    if (c.device_id[0]) begin
      r.data = {16'h0000, c.event_id, 32'h0000_0000};
      r.strb = 8'hf0;
    end else begin
      r.data = {32'h0000_0000, 16'h0000, c.event_id};
      r.strb = 8'h0f;
    end
    return r;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "stopping after the first failure");
  endtask

  task automatic check_addr(input logic [`MSI_ADDR_W-1:0] got, input logic [`MSI_ADDR_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR awaddr: got 0x%08h expected 0x%08h", got, exp));
    end
  endtask

  task automatic check_data(input logic [`MSI_DATA_W-1:0] got_data,
                            input logic [`MSI_DATA_W-1:0] exp_data,
                            input logic [`MSI_STRB_W-1:0] got_strb,
                            input logic [`MSI_STRB_W-1:0] exp_strb);
    if (got_data !== exp_data) begin
      abort_run($sformatf("ERROR wdata: got 0x%016h expected 0x%016h", got_data, exp_data));
    end
    if (got_strb !== exp_strb) begin
      abort_run($sformatf("ERROR wstrb: got 0x%02h expected 0x%02h", got_strb, exp_strb));
    end
  endtask

  task automatic check_error(input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR error: got 0x%0h expected 0x%0h", got, exp));
    end
  endtask

  task automatic check_bready(input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR bready: got 0x%0h expected 0x%0h", got, exp));
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("ERROR %s: got 0x%0h expected 0x%0h", what, got, exp));
    end
  endtask

  task automatic check_gap(input int got, input int min_gap);
    if (got < min_gap) begin
      abort_run($sformatf("ERROR awvalid gap: got 0x%0h expected at least 0x%0h", got, min_gap));
    end
  endtask

  // AXI slave model where a handshake seen here completes on the next rising edge
  always @(negedge clk) begin
    if (rst) begin
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
      aw_seen = 1'b0;
      w_seen  = 1'b0;
      b_hs    = 1'b0;
      aw_prev = 1'b0;
    end else begin
      ncyc++;
      exp_error = 1'b0;
      if (b_hs) begin
        b_hs      = 1'b0;
        bvalid    = 1'b0;
        aw_seen   = 1'b0;
        w_seen    = 1'b0;
        exp_error = (bresp != msi_pkg::OKAY);
        wr_q.push_back(cur);
      end
      check_error(error, exp_error);
      if (error) begin
        err_pulses++;
      end
      // A response is owed once both AW and W have gone through
      check_bready(bready, aw_seen && w_seen);
      // B only after both AW and W have gone through
      if (aw_seen && w_seen && !bvalid) begin
        bresp  = resp_code;
        bvalid = stall_en ? draw_bit() : 1'b1;
      end
      b_hs = bvalid && bready;
      if (awvalid && !aw_prev) begin
        rise_q.push_back(ncyc);
      end
      aw_prev = awvalid;
      awready = awvalid ? (stall_en ? draw_bit() : 1'b1) : 1'b0;
      if (awvalid && awready) begin
        cur.addr = awaddr;
        aw_seen  = 1'b1;
      end
      wready = wvalid ? (stall_en ? draw_bit() : 1'b1) : 1'b0;
      if (wvalid && wready) begin
        cur.data = wdata;
        cur.strb = wstrb;
        w_seen   = 1'b1;
      end
    end
  end

  always @(negedge clk) begin
    cyc++;
    if (axil_msi_gen_i.axil_msi_checker_i.fail_count != 0) begin
      abort_run("An assertion in the AXI checker failed");
    end else if (cyc >= CYCLE_LIMIT) begin
      abort_run($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  task automatic pulse_irq(input logic [`MSI_NUM_IRQ-1:0] lines);
    @(negedge clk);
    irq = lines;
    repeat (3) @(negedge clk);
    irq = '0;
  endtask

  task automatic wait_writes(input int n);
    while (wr_q.size() < n) begin
      @(negedge clk);
    end
  endtask

  task automatic settle();
    repeat (30) @(negedge clk);
  endtask

  task automatic check_single(input msi_pkg::irq_cfg_t c);
    wr_rec_t exp;
    exp = expect_write(c);
    check_count("write count", wr_q.size(), 1);
    check_addr(wr_q[0].addr, exp.addr);
    check_data(wr_q[0].data, exp.data, wr_q[0].strb, exp.strb);
  endtask

  task automatic load_four_lines();
    @(negedge clk);
    irq_cfg[0] = make_cfg(1'b1, 1'b0, 16'h0004, 16'h1111);
    irq_cfg[1] = make_cfg(1'b1, 1'b1, 16'h0007, 16'h2222);
    irq_cfg[2] = make_cfg(1'b1, 1'b0, 16'h0009, 16'h3333);
    irq_cfg[3] = make_cfg(1'b1, 1'b1, 16'h0010, 16'h4444);
  endtask

  task automatic test_single_even();
    @(negedge clk);
    irq_cfg[0] = make_cfg(1'b1, 1'b0, 16'h0010, 16'h00a5);
    wr_q.delete();
    pulse_irq(4'b0001);
    wait_writes(1);
    settle();
    check_single(irq_cfg[0]);
  endtask

  task automatic test_odd_second_dest();
    @(negedge clk);
    irq_cfg[2] = make_cfg(1'b1, 1'b1, 16'h0023, 16'hbeef);
    stall_en   = 1'b1;
    wr_q.delete();
    pulse_irq(4'b0100);
    wait_writes(1);
    settle();
    check_single(irq_cfg[2]);
    stall_en = 1'b0;
  endtask

  task automatic test_all_lines();
    wr_rec_t exp;
    int      hits;
    int      found;
    load_four_lines();
    wr_q.delete();
    pulse_irq(4'b1111);
    wait_writes(4);
    settle();
    check_count("write count", wr_q.size(), 4);
    for (int i = 0; i < `MSI_NUM_IRQ; i++) begin
      exp   = expect_write(irq_cfg[i]);
      hits  = 0;
      found = 0;
      foreach (wr_q[j]) begin
        if (wr_q[j].addr == exp.addr) begin
          hits++;
          found = j;
        end
      end
      check_count($sformatf("writes for line %0d", i), hits, 1);
      check_data(wr_q[found].data, exp.data, wr_q[found].strb, exp.strb);
    end
  endtask

  task automatic test_disabled_line();
    @(negedge clk);
    irq_cfg[1] = make_cfg(1'b0, 1'b0, 16'h0002, 16'h0bad);
    irq_cfg[3] = make_cfg(1'b1, 1'b1, 16'h0031, 16'h7e57);
    wr_q.delete();
    pulse_irq(4'b0010);
    repeat (40) @(negedge clk);
    check_count("writes from a disabled line", wr_q.size(), 0);
    pulse_irq(4'b1000);
    wait_writes(1);
    settle();
    check_single(irq_cfg[3]);
  endtask

  task automatic test_throttle();
    load_four_lines();
    throttle_en        = 1'b1;
    throttle_threshold = 8'd12;
    wr_q.delete();
    rise_q.delete();
    pulse_irq(4'b1111);
    wait_writes(4);
    settle();
    check_count("awvalid rises", rise_q.size(), 4);
    for (int i = 1; i < 4; i++) begin
      check_gap(rise_q[i] - rise_q[i-1], THR_CYCLES);
    end
    throttle_en = 1'b0;
  endtask

  // One SLVERR write followed by an OKAY write gives exactly one error pulse
  task automatic test_error_response();
    int pulses_before;
    load_four_lines();
    pulses_before = err_pulses;
    resp_code     = msi_pkg::SLVERR;
    wr_q.delete();
    pulse_irq(4'b0001);
    wait_writes(1);
    resp_code = msi_pkg::OKAY;
    pulse_irq(4'b0010);
    wait_writes(2);
    settle();
    check_count("write count", wr_q.size(), 2);
    check_count("error pulses", err_pulses - pulses_before, 1);
  endtask

  initial begin
    rst                = 1'b1;
    irq                = '0;
    throttle_en        = 1'b0;
    throttle_threshold = '0;
    msi_dest_addr[0]   = 32'h4000_0000;
    msi_dest_addr[1]   = 32'h8000_1000;
    for (int i = 0; i < `MSI_NUM_IRQ; i++) begin
      irq_cfg[i] = make_cfg(1'b0, 1'b0, 16'h0000, 16'h0000);
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;
    test_single_even();
    test_odd_second_dest();
    test_all_lines();
    test_disabled_line();
    test_throttle();
    test_error_response();
    $display("No errors");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+hw
hw/msi_pkg.sv
hw/msi_irq_arbiter.sv
hw/msi_write_issuer.sv
hw/axil_msi_gen.sv
testbench/axil_msi_checker.sv
testbench/axil_msi_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= axil_msi_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Errors found
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "FAIL: run did not complete"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
